// ==== logic/refill_pkg.sv ====
// ####################################################################
// refill package: line geometry, data and address types, and the
// state encoding of the return buffer
// ####################################################################
`default_nettype none

package refill_pkg;

    localparam int offset_width   = 2;
    localparam int words_per_line = 1 << offset_width;
    localparam int line_idx_width = 3;
    localparam int line_count     = 1 << line_idx_width;
    localparam int word_width     = 32;
    localparam int mem_words      = line_count * words_per_line;

    typedef logic [word_width-1:0]                  word_t;
    typedef logic [words_per_line*word_width-1:0]   line_t;     // word 0 in lowest bits
    typedef logic [line_idx_width-1:0]              line_idx_t;
    typedef logic [offset_width-1:0]                word_idx_t;
    typedef logic [line_idx_width+offset_width-1:0] mem_addr_t; // {line, word}

    // one beat of the burst return
    typedef struct packed {
        word_t data;
        logic  valid;
        logic  last;
    } beat_t;

    typedef enum logic [1:0] {
        rbuf_idle    = 2'd0,
        rbuf_receive = 2'd1,
        rbuf_send    = 2'd2
    } rbuf_state_t;

endpackage

`default_nettype wire

// ==== logic/backing_memory.sv ====
// ####################################################################
// backing memory: word store loaded from outside, streams one line
// back as a burst of beats after each fetch pulse
// ####################################################################
`default_nettype none

module backing_memory (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  mem_we,
    input  refill_pkg::mem_addr_t mem_addr,
    input  refill_pkg::word_t     mem_wdata,
    input  logic                  mem_stall,

    input  logic                  fetch_start,
    input  refill_pkg::line_idx_t fetch_line,

    output refill_pkg::beat_t     beat
);
    import refill_pkg::*;

    word_t     mem [mem_words];

    logic      busy;
    line_idx_t cur_line;
    word_idx_t word_cnt;
    logic      last_word;

    word_t     beat_data;
    logic      beat_valid;
    logic      beat_last;

    // load port, plain synchronous write
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    assign last_word = (word_cnt == word_idx_t'(words_per_line - 1));

    // burst control
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy       <= 1'b0;
            cur_line   <= '0;
            word_cnt   <= '0;
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
            if (fetch_start && !busy) begin
                // first beat goes out right away
                cur_line   <= fetch_line;
                word_cnt   <= word_idx_t'(1);
                busy       <= (words_per_line > 1);
                beat_valid <= 1'b1;
                beat_last  <= (words_per_line == 1);
            end else if (busy && !mem_stall) begin
                word_cnt   <= word_cnt + word_idx_t'(1);
                beat_valid <= 1'b1;
                beat_last  <= last_word;
                if (last_word) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // beat payload
    always_ff @(posedge clk) begin
        if (fetch_start && !busy) begin
            beat_data <= mem[{fetch_line, word_idx_t'(0)}];
        end else if (busy && !mem_stall) begin
            beat_data <= mem[{cur_line, word_cnt}];
        end
    end

    assign beat = '{data: beat_data, valid: beat_valid, last: beat_last};

    // the line store must wait for the whole burst
    a_no_fetch_in_burst: assert property (
        @(posedge clk) disable iff (!rstn)
        fetch_start |-> !busy
    ) else $error("fetch_start during a burst");

endmodule

`default_nettype wire

// ==== logic/return_buffer.sv ====
// ####################################################################
// return buffer: shifts burst beats into a full line and holds it
// until the line store is ready to take it
// ####################################################################
`default_nettype none

module return_buffer (
    input  logic              clk,
    input  logic              rstn,

    input  refill_pkg::beat_t beat,

    input  logic              fill_req,
    input  logic              line_rdy,
    output logic              data_ok,
    output refill_pkg::line_t fill_line
);
    import refill_pkg::*;

    rbuf_state_t state;
    rbuf_state_t next_state;
    line_t       line_q;
    line_t       line_shift;
    logic        transfer;

    assign transfer   = data_ok && fill_req && line_rdy;
    assign line_shift = {beat.data, line_q[$bits(line_t)-1:word_width]};  // new word at top

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= rbuf_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            rbuf_idle: begin
                if (beat.valid && beat.last) begin
                    next_state = rbuf_send;
                end else if (beat.valid) begin
                    next_state = rbuf_receive;
                end
            end
            rbuf_receive: begin
                if (beat.valid && beat.last) begin
                    next_state = rbuf_send;
                end
            end
            rbuf_send: begin
                if (transfer) begin
                    next_state = rbuf_idle;
                end
            end
            default: next_state = rbuf_idle;
        endcase
    end

    // line register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_q <= '0;
        end else begin
            unique case (state)
                rbuf_idle: begin
                    if (beat.valid) begin
                        line_q <= line_shift;
                    end else begin
                        line_q <= '0;
                    end
                end
                rbuf_receive: begin
                    if (beat.valid) begin
                        line_q <= line_shift;
                    end
                end
                rbuf_send: begin
                    if (transfer) begin
                        line_q <= '0;  // taken
                    end
                end
                default: line_q <= '0;
            endcase
        end
    end

    assign data_ok   = (state == rbuf_send);
    assign fill_line = line_q;

    // memory must not stream while a line waits here
    a_no_beat_in_send: assert property (
        @(posedge clk) disable iff (!rstn)
        state == rbuf_send |-> !beat.valid
    ) else $error("beat arrived while holding a line");

    // no discard path, so a held line needs its request
    a_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        data_ok |-> fill_req
    ) else $error("line held with no refill pending");

endmodule

`default_nettype wire

// ==== logic/line_store.sv ====
// ####################################################################
// line store: line data array with a refill request side and a
// single-word lookup port sharing one array port
// ####################################################################
`default_nettype none

module line_store (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  refill_start,
    input  refill_pkg::line_idx_t refill_line,

    output logic                  fetch_start,
    output refill_pkg::line_idx_t fetch_line,

    output logic                  fill_req,
    output logic                  line_rdy,
    input  logic                  data_ok,
    input  refill_pkg::line_t     fill_line,
    output logic                  refill_done,

    input  logic                  lookup_en,
    input  refill_pkg::line_idx_t lookup_line,
    input  refill_pkg::word_idx_t lookup_word,
    output refill_pkg::word_t     lookup_data
);
    import refill_pkg::*;

    line_t     line_array [line_count];
    line_idx_t pend_line;
    logic      line_write;

    // lookup owns the port when it asks
    assign line_rdy   = !lookup_en;
    assign line_write = data_ok && fill_req && line_rdy;
    assign fetch_line = pend_line;

    // refill request tracking
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fill_req    <= 1'b0;
            pend_line   <= '0;
            fetch_start <= 1'b0;
            refill_done <= 1'b0;
        end else begin
            fetch_start <= 1'b0;
            refill_done <= 1'b0;
            if (line_write) begin
                fill_req    <= 1'b0;
                refill_done <= 1'b1;
            end else if (refill_start && !fill_req) begin
                fill_req    <= 1'b1;
                pend_line   <= refill_line;
                fetch_start <= 1'b1;
            end
        end
    end

    // line array, written a whole line at a time
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < line_count; i++) begin
                line_array[i] <= '0;
            end
        end else if (line_write) begin
            line_array[pend_line] <= fill_line;
        end
    end

    // registered word read
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            lookup_data <= line_array[lookup_line][lookup_word*word_width +: word_width];
        end
    end

    // buffer lets go of the line on the write edge
    a_line_released: assert property (
        @(posedge clk) disable iff (!rstn)
        refill_done |-> !data_ok
    ) else $error("data_ok still high after the line was written");

endmodule

`default_nettype wire

// ==== logic/refill_top.sv ====
// ####################################################################
// refill subsystem top: backing memory, return buffer, line store
// ####################################################################
`default_nettype none

module refill_top (
    input  logic                  clk,
    input  logic                  rstn,

    // memory load port
    input  logic                  mem_we,
    input  refill_pkg::mem_addr_t mem_addr,
    input  refill_pkg::word_t     mem_wdata,
    input  logic                  mem_stall,

    // refill command
    input  logic                  refill_start,
    input  refill_pkg::line_idx_t refill_line,
    output logic                  refill_done,

    // lookup port
    input  logic                  lookup_en,
    input  refill_pkg::line_idx_t lookup_line,
    input  refill_pkg::word_idx_t lookup_word,
    output refill_pkg::word_t     lookup_data
);
    import refill_pkg::*;

    logic      fetch_start;
    line_idx_t fetch_line;
    beat_t     beat;
    logic      fill_req;
    logic      line_rdy;
    logic      data_ok;
    line_t     fill_line;

    backing_memory u_backing_memory (
        .clk         (clk),
        .rstn        (rstn),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_stall   (mem_stall),
        .fetch_start (fetch_start),
        .fetch_line  (fetch_line),
        .beat        (beat)
    );

    return_buffer u_return_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .beat      (beat),
        .fill_req  (fill_req),
        .line_rdy  (line_rdy),
        .data_ok   (data_ok),
        .fill_line (fill_line)
    );

    line_store u_line_store (
        .clk          (clk),
        .rstn         (rstn),
        .refill_start (refill_start),
        .refill_line  (refill_line),
        .fetch_start  (fetch_start),
        .fetch_line   (fetch_line),
        .fill_req     (fill_req),
        .line_rdy     (line_rdy),
        .data_ok      (data_ok),
        .fill_line    (fill_line),
        .refill_done  (refill_done),
        .lookup_en    (lookup_en),
        .lookup_line  (lookup_line),
        .lookup_word  (lookup_word),
        .lookup_data  (lookup_data)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// ####################################################################
// testbench clock and reset: 10 ns clock, reset low for 2 cycles
// ####################################################################
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk  = 1'b0;
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

// ==== verification/refill_tb.sv ====
// ####################################################################
// refill testbench: table of refills checked against a model of the
// backing memory and the line array
// ####################################################################
`default_nettype none

module refill_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import refill_pkg::*;

    typedef struct packed {
        line_idx_t line;
        logic      stall;     // random mem_stall during the burst
        logic      lookup;    // hold lookup_en while the line waits in send
        logic      dup;       // second refill_start while pending
        line_idx_t dup_line;
        logic      reload;    // new memory words before the refill
    } entry_t;

    localparam int num_entries   = 10;
    localparam int refill_limit  = 40;
    localparam int load_cycles   = 5 * mem_words + 20;  // load and two full sweeps
    localparam int timeout_limit = num_entries * 40 + load_cycles;

    logic      clk;
    logic      rstn;
    logic      mem_we;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    logic      mem_stall;
    logic      refill_start;
    line_idx_t refill_line;
    logic      refill_done;
    logic      lookup_en;
    line_idx_t lookup_line;
    word_idx_t lookup_word;
    word_t     lookup_data;

    entry_t      refill_table [num_entries];
    word_t       model_mem [mem_words];
    word_t       model_lines [line_count][words_per_line];
    logic [31:0] rng_state;
    int          errors;
    int          cycle_count;

    tb_clock_gen u_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    refill_top DUT (
        .clk          (clk),
        .rstn         (rstn),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_stall    (mem_stall),
        .refill_start (refill_start),
        .refill_line  (refill_line),
        .refill_done  (refill_done),
        .lookup_en    (lookup_en),
        .lookup_line  (lookup_line),
        .lookup_word  (lookup_word),
        .lookup_data  (lookup_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic entry_t make_entry(input int line, input bit stall, input bit lookup,
                                          input bit dup, input int dup_line, input bit reload);
        entry_t e;
        e.line     = line_idx_t'(line);
        e.stall    = stall;
        e.lookup   = lookup;
        e.dup      = dup;
        e.dup_line = line_idx_t'(dup_line);
        e.reload   = reload;
        return e;
    endfunction

    task automatic load_word(input mem_addr_t addr);
        word_t value;
        value = draw_random();
        @(posedge clk);
        mem_we    <= 1'b1;
        mem_addr  <= addr;
        mem_wdata <= value;
        model_mem[addr] = value;
    endtask

    task automatic end_load();
        @(posedge clk);
        mem_we <= 1'b0;
    endtask

    // one registered lookup; refill_done must stay quiet meanwhile
    task automatic read_word(input line_idx_t line, input word_idx_t word, output word_t data);
        @(posedge clk);
        lookup_en   <= 1'b1;
        lookup_line <= line;
        lookup_word <= word;
        @(posedge clk);
        lookup_en <= 1'b0;
        @(negedge clk);
        data = lookup_data;
        if (refill_done !== 1'b0) begin
            $display("MISMATCH at %0t: refill_done high with no refill running", $time);
            errors++;
        end
    endtask

    task automatic read_line(input line_idx_t line);
        word_t data;
        for (int w = 0; w < words_per_line; w++) begin
            read_word(line, word_idx_t'(w), data);
            if (data !== model_lines[line][w]) begin
                $display("MISMATCH at %0t: line %0d word %0d read %h, expected %h",
                         $time, line, w, data, model_lines[line][w]);
                errors++;
            end
        end
    endtask

    task automatic check_all_lines();
        for (int l = 0; l < line_count; l++) begin
            read_line(line_idx_t'(l));
        end
    endtask

    task automatic run_refill(input entry_t e, input int hold);
        int          cyc;
        int          expect_cyc;
        logic        done;
        logic        look;
        logic        chk;
        word_idx_t   chk_word;
        logic [31:0] r;
        expect_cyc = e.lookup ? 7 + hold : 7;
        done = 1'b0;
        chk  = 1'b0;
        cyc  = 0;
        chk_word = '0;
        @(posedge clk);
        refill_start <= 1'b1;
        refill_line  <= e.line;
        while (!done && cyc < refill_limit) begin
            @(posedge clk);
            cyc++;
            r = draw_random();
            refill_start <= e.dup && (cyc == 2);
            refill_line  <= (e.dup && cyc == 2) ? e.dup_line : e.line;
            mem_stall    <= e.stall ? r[7] : 1'b0;
            look = e.lookup && (cyc >= 6) && (cyc < 6 + hold);  // line is in send by now
            lookup_en   <= look;
            lookup_line <= e.line;
            lookup_word <= word_idx_t'(cyc);
            @(negedge clk);
            if (chk && lookup_data !== model_lines[e.line][chk_word]) begin
                $display("MISMATCH at %0t: line %0d word %0d read %h during refill, expected old %h",
                         $time, e.line, chk_word, lookup_data, model_lines[e.line][chk_word]);
                errors++;
            end
            chk      = look;
            chk_word = word_idx_t'(cyc);
            done     = refill_done;
        end
        @(posedge clk);
        mem_stall <= 1'b0;
        if (!done) begin
            $display("refill of line %0d: refill_done never came within %0d cycles",
                     e.line, refill_limit);
            errors++;
        end else if (!e.stall && cyc != expect_cyc) begin
            $display("MISMATCH at %0t: refill of line %0d took %0d cycles, expected %0d",
                     $time, e.line, cyc, expect_cyc);
            errors++;
        end
        for (int w = 0; w < words_per_line; w++) begin
            model_lines[e.line][w] = model_mem[{e.line, word_idx_t'(w)}];
        end
    endtask

    task automatic run_entry(input entry_t e);
        int hold;
        if (e.reload) begin
            for (int w = 0; w < words_per_line; w++) begin
                load_word({e.line, word_idx_t'(w)});
            end
            end_load();
        end
        hold = int'(draw_random() % 8) + 1;
        run_refill(e, hold);
        if (e.dup) begin
            repeat (12) begin
                @(negedge clk);
                if (refill_done !== 1'b0) begin
                    $display("MISMATCH at %0t: second refill_done after an ignored start", $time);
                    errors++;
                end
            end
        end
        read_line(e.line);
        if (e.dup) begin
            read_line(e.dup_line);
        end
    endtask

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped: no result after %0d cycles, %0d errors so far",
                 timeout_limit, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        mem_we       = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_stall    = 1'b0;
        refill_start = 1'b0;
        refill_line  = '0;
        lookup_en    = 1'b0;
        lookup_line  = '0;
        lookup_word  = '0;
        errors       = 0;
        rng_state    = 32'd5673;

        refill_table[0] = make_entry(2, 0, 0, 0, 0, 0);
        refill_table[1] = make_entry(5, 0, 0, 0, 0, 0);
        refill_table[2] = make_entry(0, 1, 0, 0, 0, 0);
        refill_table[3] = make_entry(7, 1, 0, 0, 0, 0);
        refill_table[4] = make_entry(3, 0, 1, 0, 0, 0);  // lookup entries run without stalls
        refill_table[5] = make_entry(1, 0, 0, 1, 4, 0);
        refill_table[6] = make_entry(2, 0, 0, 0, 0, 1);  // overwrite a filled line
        refill_table[7] = make_entry(6, 1, 0, 0, 0, 0);
        refill_table[8] = make_entry(4, 1, 0, 0, 0, 1);
        refill_table[9] = make_entry(5, 0, 1, 0, 0, 1);

        for (int l = 0; l < line_count; l++) begin
            for (int w = 0; w < words_per_line; w++) begin
                model_lines[l][w] = '0;
            end
        end

        wait (rstn === 1'b1);
        check_all_lines();  // array clear after reset

        for (int a = 0; a < mem_words; a++) begin
            load_word(mem_addr_t'(a));
        end
        end_load();

        for (int i = 0; i < num_entries; i++) begin
            run_entry(refill_table[i]);
        end
        check_all_lines();

        $display("refill_tb: %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/refill_pkg.sv
logic/backing_memory.sv
logic/return_buffer.sv
logic/line_store.sv
logic/refill_top.sv
verification/tb_clock_gen.sv
verification/refill_tb.sv

// ==== Bender.yml ====
package:
  name: refill
  description: "Cache line refill path with burst return buffer"

sources:
  - logic/refill_pkg.sv
  - logic/backing_memory.sv
  - logic/return_buffer.sv
  - logic/line_store.sv
  - logic/refill_top.sv

  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/refill_tb.sv
